// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_muldiv_unit
FLIST     := muldiv_unit.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== div_iter.sv ====
`timescale 1ns/10ps

module div_iter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  div_start,
    input  muldiv_pkg::md_req_t   div_req,
    input  logic                  div_out_ready,
    output logic                  div_busy,
    output logic                  div_out_valid,
    output muldiv_pkg::hilo_wr_t  div_wr
);
    import muldiv_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_RUN,
        ST_FIX,
        ST_DONE
    } div_state_e;

    div_state_e             state_q;
    logic [DIV_CNT_W-1:0]   cnt_q;

    logic                   sgn_q;
    logic                   neg_quo_q;
    logic                   neg_rem_q;
    logic [DATA_W-1:0]      dvd_q;
    logic [DATA_W-1:0]      dvs_q;
    logic [DATA_W-1:0]      quo_q;
    logic [DATA_W-1:0]      rem_q;
    hilo_wr_t               res_q;

    logic [DATA_W:0]        rem_sh;
    logic [DATA_W:0]        diff;
    logic                   dvd_neg;
    logic                   dvs_neg;
    logic                   dvs_zero;

    // one restoring step
    assign rem_sh = {rem_q, quo_q[DATA_W-1]};
    assign diff   = rem_sh - {1'b0, dvs_q};

    assign dvd_neg  = sgn_q && dvd_q[DATA_W-1];
    assign dvs_neg  = sgn_q && dvs_q[DATA_W-1];
    assign dvs_zero = (dvs_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (div_start) begin
                        state_q <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    cnt_q   <= '0;
                    state_q <= ST_RUN;
                end
                ST_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == DIV_CNT_W'(DIV_CYCLES - 1)) begin
                        state_q <= ST_FIX;
                    end
                end
                ST_FIX: begin
                    state_q <= ST_DONE;
                end
                ST_DONE: begin
                    if (div_out_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            ST_IDLE: begin
                if (div_start) begin
                    sgn_q <= (div_req.op == MD_DIV);
                    dvd_q <= div_req.src1;
                    dvs_q <= div_req.src2;
                end
            end
            ST_LOAD: begin
                // work on magnitudes from here on
                neg_quo_q <= dvd_neg ^ dvs_neg;
                neg_rem_q <= dvd_neg;
                quo_q     <= dvd_neg ? -dvd_q : dvd_q;
                dvs_q     <= dvs_neg ? -dvs_q : dvs_q;
                rem_q     <= '0;
            end
            ST_RUN: begin
                if (!diff[DATA_W]) begin
                    rem_q <= diff[DATA_W-1:0];
                    quo_q <= {quo_q[DATA_W-2:0], 1'b1};
                end else begin
                    rem_q <= rem_sh[DATA_W-1:0];
                    quo_q <= {quo_q[DATA_W-2:0], 1'b0};
                end
            end
            ST_FIX: begin
                // divide by zero gives all ones and the untouched dividend
                if (dvs_zero) begin
                    res_q.lo <= '1;
                    res_q.hi <= dvd_q;
                end else begin
                    res_q.lo <= neg_quo_q ? -quo_q : quo_q;
                    res_q.hi <= neg_rem_q ? -rem_q : rem_q;
                end
            end
            default: ;
        endcase
    end

    assign div_busy      = (state_q != ST_IDLE);
    assign div_out_valid = (state_q == ST_DONE);
    assign div_wr        = res_q;

endmodule

// ==== hilo_regs.sv ====
`timescale 1ns/10ps

module hilo_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mul_wr_valid,
    input  muldiv_pkg::hilo_wr_t          mul_wr,
    input  logic                          div_out_valid,
    input  muldiv_pkg::hilo_wr_t          div_wr,
    input  logic                          mv_valid,
    input  muldiv_pkg::md_op_e            mv_op,
    input  logic [muldiv_pkg::DATA_W-1:0] mv_data,
    output logic                          div_out_ready,
    output logic                          rd_valid,
    output logic [muldiv_pkg::DATA_W-1:0] rd_data
);
    import muldiv_pkg::*;

    logic [DATA_W-1:0] hi_q;
    logic [DATA_W-1:0] lo_q;
    logic              is_mf;

    // multiplier result has priority over the divider
    assign div_out_ready = !mul_wr_valid;

    assign is_mf = (mv_op == MD_MFHI) || (mv_op == MD_MFLO);

    always_ff @(posedge clk) begin
        if (rst) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (mul_wr_valid) begin
            hi_q <= mul_wr.hi;
            lo_q <= mul_wr.lo;
        end else if (div_out_valid) begin
            hi_q <= div_wr.hi;
            lo_q <= div_wr.lo;
        end else if (mv_valid && mv_op == MD_MTHI) begin
            hi_q <= mv_data;
        end else if (mv_valid && mv_op == MD_MTLO) begin
            lo_q <= mv_data;
        end
    end

    // registered read port for move-from
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= mv_valid && is_mf;
        end
    end

    always_ff @(posedge clk) begin
        if (mv_valid && is_mf) begin
            rd_data <= (mv_op == MD_MFHI) ? hi_q : lo_q;
        end
    end

endmodule

// ==== md_issue.sv ====
`timescale 1ns/10ps

module md_issue (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  muldiv_pkg::md_req_t           req,
    input  logic                          mul_busy,
    input  logic                          div_busy,
    output logic                          req_ready,
    output logic                          mul_valid,
    output muldiv_pkg::md_req_t           mul_req,
    output logic                          div_start,
    output muldiv_pkg::md_req_t           div_req,
    output logic                          mv_valid,
    output muldiv_pkg::md_op_e            mv_op,
    output logic [muldiv_pkg::DATA_W-1:0] mv_data
);
    import muldiv_pkg::*;

    md_req_t req_q;
    logic    vld_q;
    logic    is_mul;
    logic    is_div;
    logic    is_mv;
    logic    go;

    // operation class of the held request
    always_comb begin
        is_mul = 1'b0;
        is_div = 1'b0;
        is_mv  = 1'b0;
        case (req_q.op)
            MD_MULT, MD_MULTU:                  is_mul = 1'b1;
            MD_DIV, MD_DIVU:                    is_div = 1'b1;
            MD_MFHI, MD_MFLO, MD_MTHI, MD_MTLO: is_mv  = 1'b1;
            default: ;
        endcase
    end

    // hazard rules keep HI/LO writes in program order
    always_comb begin
        if (is_mul) begin
            // multiplies may overlap each other but not a running divide
            go = !div_busy;
        end else if (is_div || is_mv) begin
            go = !div_busy && !mul_busy;
        end else begin
            // nop just drains
            go = 1'b1;
        end
    end

    assign req_ready = !vld_q || go;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= 1'b0;
        end else if (req_ready) begin
            vld_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready) begin
            req_q <= req;
        end
    end

    assign mul_valid = vld_q && is_mul && go;
    assign mul_req   = req_q;
    assign div_start = vld_q && is_div && go;
    assign div_req   = req_q;
    assign mv_valid  = vld_q && is_mv && go;
    assign mv_op     = req_q.op;
    assign mv_data   = req_q.src1;

endmodule

// ==== mul_pipe.sv ====
`timescale 1ns/10ps

module mul_pipe (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mul_valid,
    input  muldiv_pkg::md_req_t   mul_req,
    output logic                  mul_wr_valid,
    output muldiv_pkg::hilo_wr_t  mul_wr,
    output logic                  mul_busy
);
    import muldiv_pkg::*;

    logic                         s1_vld;
    logic                         s2_vld;
    logic                         sgn;
    // one extra bit so both signed and unsigned fit a signed multiply
    logic signed [DATA_W:0]       a_q;
    logic signed [DATA_W:0]       b_q;
    logic signed [2*DATA_W+1:0]   prod_full;
    logic [2*DATA_W-1:0]          prod_q;

    assign sgn = (mul_req.op == MD_MULT);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end else begin
            s1_vld <= mul_valid;
            s2_vld <= s1_vld;
        end
    end

    // stage one registers the extended operands
    always_ff @(posedge clk) begin
        a_q <= {sgn & mul_req.src1[DATA_W-1], mul_req.src1};
        b_q <= {sgn & mul_req.src2[DATA_W-1], mul_req.src2};
    end

    assign prod_full = a_q * b_q;

    // stage two registers the product
    always_ff @(posedge clk) begin
        prod_q <= prod_full[2*DATA_W-1:0];
    end

    assign mul_wr_valid = s2_vld;
    assign mul_wr.hi    = prod_q[2*DATA_W-1:DATA_W];
    assign mul_wr.lo    = prod_q[DATA_W-1:0];
    assign mul_busy     = s1_vld || s2_vld;

endmodule

// ==== muldiv_pkg.sv ====
package muldiv_pkg;

    // operand width fixed by the instruction set
    localparam int DATA_W = 32;

    // one quotient bit per divider iteration
    localparam int DIV_CYCLES = 32;
    localparam int DIV_CNT_W  = $clog2(DIV_CYCLES);

    // operation codes seen by the unit
    typedef enum logic [3:0] {
        MD_NOP   = 4'd0,
        MD_MULT  = 4'd1,
        MD_MULTU = 4'd2,
        MD_DIV   = 4'd3,
        MD_DIVU  = 4'd4,
        MD_MFHI  = 4'd5,
        MD_MFLO  = 4'd6,
        MD_MTHI  = 4'd7,
        MD_MTLO  = 4'd8
    } md_op_e;

    // one request where src1 is the dividend for DIV and DIVU
    typedef struct packed {
        md_op_e              op;
        logic [DATA_W-1:0]   src1;
        logic [DATA_W-1:0]   src2;
    } md_req_t;

    // full HI/LO result
    typedef struct packed {
        logic [DATA_W-1:0]   hi;
        logic [DATA_W-1:0]   lo;
    } hilo_wr_t;

endpackage

// ==== muldiv_unit.f ====
muldiv_pkg.sv
md_issue.sv
mul_pipe.sv
div_iter.sv
hilo_regs.sv
muldiv_unit.sv
tb_muldiv_unit.sv

// ==== muldiv_unit.sv ====
`timescale 1ns/10ps

module muldiv_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  muldiv_pkg::md_req_t           req,
    output logic                          req_ready,
    output logic                          rd_valid,
    output logic [muldiv_pkg::DATA_W-1:0] rd_data
);
    import muldiv_pkg::*;

    logic              mul_valid;
    md_req_t           mul_req;
    logic              mul_wr_valid;
    hilo_wr_t          mul_wr;
    logic              mul_busy;

    logic              div_start;
    md_req_t           div_req;
    logic              div_busy;
    logic              div_out_valid;
    logic              div_out_ready;
    hilo_wr_t          div_wr;

    logic              mv_valid;
    md_op_e            mv_op;
    logic [DATA_W-1:0] mv_data;

    md_issue u_issue (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .mul_busy  (mul_busy),
        .div_busy  (div_busy),
        .req_ready (req_ready),
        .mul_valid (mul_valid),
        .mul_req   (mul_req),
        .div_start (div_start),
        .div_req   (div_req),
        .mv_valid  (mv_valid),
        .mv_op     (mv_op),
        .mv_data   (mv_data)
    );

    mul_pipe u_mul (
        .clk          (clk),
        .rst          (rst),
        .mul_valid    (mul_valid),
        .mul_req      (mul_req),
        .mul_wr_valid (mul_wr_valid),
        .mul_wr       (mul_wr),
        .mul_busy     (mul_busy)
    );

    div_iter u_div (
        .clk           (clk),
        .rst           (rst),
        .div_start     (div_start),
        .div_req       (div_req),
        .div_out_ready (div_out_ready),
        .div_busy      (div_busy),
        .div_out_valid (div_out_valid),
        .div_wr        (div_wr)
    );

    hilo_regs u_hilo (
        .clk           (clk),
        .rst           (rst),
        .mul_wr_valid  (mul_wr_valid),
        .mul_wr        (mul_wr),
        .div_out_valid (div_out_valid),
        .div_wr        (div_wr),
        .mv_valid      (mv_valid),
        .mv_op         (mv_op),
        .mv_data       (mv_data),
        .div_out_ready (div_out_ready),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data)
    );

endmodule

// ==== tb_muldiv_unit.sv ====
`timescale 1ns/10ps

module tb_muldiv_unit;
    import muldiv_pkg::*;

    localparam int N_MUL = 20;
    localparam int N_DIV = 12;
    localparam int N_MIX = 200;
    // upper bound on issued ops including the directed ones
    localparam int N_OPS = 3 * N_MUL + 3 * N_DIV + N_MIX + 32;
    localparam int T_CLK = 4;

    logic              clk;
    logic              rst;
    logic              req_valid;
    md_req_t           req;
    logic              req_ready;
    logic              rd_valid;
    logic [DATA_W-1:0] rd_data;

    logic [DATA_W-1:0] rng;
    hilo_wr_t          model;
    logic [DATA_W-1:0] exp_data[$];
    int                exp_lat[$];
    int                acc_cyc[$];
    int                cyc = 0;
    int                errors = 0;
    int                end_errors = 0;

    muldiv_unit dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(T_CLK / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [DATA_W-1:0] xorshift(input logic [DATA_W-1:0] s);
        logic [DATA_W-1:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [DATA_W-1:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    // corner values mixed into random operands
    function logic [DATA_W-1:0] pick_operand();
        logic [DATA_W-1:0] r;
        r = rand32();
        case (r[2:0])
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return {1'b1, {(DATA_W-1){1'b0}}};
            3'd3:    return 32'd1 << r[8:4];
            default: return rand32();
        endcase
    endfunction

    function automatic md_req_t mk(input md_op_e op, input logic [DATA_W-1:0] a,
                                   input logic [DATA_W-1:0] b);
        md_req_t r;
        r.op   = op;
        r.src1 = a;
        r.src2 = b;
        return r;
    endfunction

    // expected HI/LO after one request from the instruction rules
    function automatic hilo_wr_t ref_model(input md_req_t r, input hilo_wr_t cur);
        hilo_wr_t            nxt;
        longint              sa;
        longint              sb;
        logic [2*DATA_W-1:0] p;
        nxt = cur;
        sa  = longint'($signed(r.src1));
        sb  = longint'($signed(r.src2));
        case (r.op)
            MD_MULT: begin
                p   = sa * sb;
                nxt = p;
            end
            MD_MULTU: begin
                p   = {32'b0, r.src1} * {32'b0, r.src2};
                nxt = p;
            end
            MD_DIV, MD_DIVU: begin
                if (r.src2 == '0) begin
                    nxt.lo = '1;
                    nxt.hi = r.src1;
                end else if (r.op == MD_DIV) begin
                    // 64-bit math keeps min / -1 from overflowing
                    nxt.lo = DATA_W'(sa / sb);
                    nxt.hi = DATA_W'(sa % sb);
                end else begin
                    nxt.lo = r.src1 / r.src2;
                    nxt.hi = r.src1 % r.src2;
                end
            end
            MD_MTHI: nxt.hi = r.src1;
            MD_MTLO: nxt.lo = r.src1;
            default: ;
        endcase
        return nxt;
    endfunction

    task automatic check(input string name, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // called just after a rising edge and returns the same way
    task automatic send(input md_req_t r, input int lat);
        req_valid = 1'b1;
        req       = r;
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        if (r.op == MD_MFHI || r.op == MD_MFLO) begin
            exp_data.push_back(r.op == MD_MFHI ? model.hi : model.lo);
            exp_lat.push_back(lat);
            acc_cyc.push_back(cyc);
        end else begin
            model = ref_model(r, model);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic op_and_read(input md_op_e op, input logic [DATA_W-1:0] a,
                               input logic [DATA_W-1:0] b);
        send(mk(op, a, b), 0);
        send(mk(MD_MFHI, '0, '0), 0);
        send(mk(MD_MFLO, '0, '0), 0);
    endtask

    // compare each read against the model in program order
    always @(negedge clk) begin
        int lat;
        int acc;
        if (!rst && rd_valid) begin
            if (exp_data.size() == 0) begin
                errors++;
                $display("rd_valid at %0t with no move-from op outstanding", $time);
            end else begin
                check("rd_data", rd_data, exp_data.pop_front());
                lat = exp_lat.pop_front();
                acc = acc_cyc.pop_front();
                if (lat != 0) begin
                    check("rd_valid latency", cyc - acc, lat);
                end
            end
        end
    end

    initial begin
        #(N_OPS * (DIV_CYCLES + 6) * T_CLK + 1000);
        $display("timeout: the run did not finish in the expected time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [DATA_W-1:0] r;
        md_op_e            op;
        int                i;
        rng       = 32'd42;
        model     = '0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check("req_ready", req_ready, 1'b1);

        // reset values and read latency with no hazard
        send(mk(MD_MFHI, '0, '0), 2);
        send(mk(MD_MFLO, '0, '0), 2);

        send(mk(MD_MTHI, rand32(), '0), 0);
        send(mk(MD_MTLO, rand32(), '0), 0);
        send(mk(MD_MFHI, '0, '0), 2);
        send(mk(MD_MFLO, '0, '0), 2);

        // multiplies go in back-to-back pairs
        for (i = 0; i < N_MUL; i++) begin
            r  = rand32();
            op = r[0] ? MD_MULT : MD_MULTU;
            send(mk(op, pick_operand(), pick_operand()), 0);
            if (i % 2 == 1) begin
                send(mk(MD_MFHI, '0, '0), 0);
                send(mk(MD_MFLO, '0, '0), 0);
            end
        end

        for (i = 0; i < N_DIV; i++) begin
            r = rand32();
            op_and_read(r[0] ? MD_DIV : MD_DIVU, pick_operand(), pick_operand());
        end

        // defined corner results
        op_and_read(MD_DIV, 32'h1234_5678, '0);
        op_and_read(MD_DIVU, 32'hfedc_ba98, '0);
        op_and_read(MD_DIV, 32'h8000_0000, 32'hffff_ffff);
        op_and_read(MD_DIV, 32'hffff_fff9, 32'd2);
        op_and_read(MD_DIV, 32'd7, 32'hffff_fffe);

        // random mix with random gaps
        for (i = 0; i < N_MIX; i++) begin
            r  = rand32();
            op = md_op_e'(4'(r[2:0]) + 4'd1);
            send(mk(op, pick_operand(), pick_operand()), 0);
            idle(int'(r[9:8]));
        end

        for (i = 0; i < 4 * DIV_CYCLES && exp_data.size() != 0; i++) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (exp_data.size() != 0) begin
            end_errors++;
            $display("%0d move-from results never arrived", exp_data.size());
        end

        $display("check errors: %0d, other errors: %0d", errors, end_errors);
        if (errors == 0 && end_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
